// File: Bender.yml
package:
  name: acq_ctrl

sources:
  - files:
      - src/acq_pkg.sv
      - src/acq_sequencer.sv
      - src/bit_timer.sv
      - src/tx_buffer.sv
      - src/serial_shifter.sv
      - src/acq_top.sv
  - target: test
    files:
      - dv/acq_tb.sv

// File: dv/acq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module acq_tb;

	localparam int NUM_SAMPLES = 40;
	localparam int BITS = acq_pkg::BIT_CYCLES;
	localparam int FRAME_CYCLES = 10 * BITS;
	// one frame per sample plus conversion slack, then reset and drain margin
	localparam int TIMEOUT_CYCLES = NUM_SAMPLES * (FRAME_CYCLES + 40) + 200;

	logic       clock = 1'b0;
	logic       rst_n;
	logic       eoc;
	logic [7:0] data_in;
	logic       dsr;
	wire        soc;
	wire        mux_en;
	wire  [2:0] channel;
	wire        data_out;
	wire        error;

	// stimulus drawn up front so a single seeded stream feeds every process
	int unsigned busy_len [NUM_SAMPLES];
	logic [7:0]  conv_data [NUM_SAMPLES];
	logic        dsr_val [NUM_SAMPLES];

	// reference model, samples converted but not yet resolved on the line
	acq_pkg::sample_t exp_q [$];
	logic             drop_q [$];

	int errors = 0;
	int checks = 0;
	int conv_count = 0;
	int frames_rx = 0;
	int exp_frames = 0;
	// samples between soc rise and end of their frame
	int in_flight = 0;

	always #20 clock = ~clock;

	acq_top dut0 (
		.clock    (clock),
		.rst_n    (rst_n),
		.eoc      (eoc),
		.data_in  (data_in),
		.dsr      (dsr),
		.soc      (soc),
		.mux_en   (mux_en),
		.channel  (channel),
		.data_out (data_out),
		.error    (error)
	);

	task automatic compare_sample(input acq_pkg::sample_t act, input acq_pkg::sample_t exp,
			input string what);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s, got ch %0d data %02h, expected ch %0d data %02h",
				$time, what, act.channel, act.data, exp.channel, exp.data);
		end
	endtask

	task automatic compare_byte(input logic [7:0] act, input logic [7:0] exp, input string what);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s, got %02h, expected %02h", $time, what, act, exp);
		end
	endtask

	task automatic compare_flag(input logic act, input logic exp, input string what);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s, got %b, expected %b", $time, what, act, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// converter: busy for a random time after soc, result held until soc drops
	initial begin : converter_model
		acq_pkg::sample_t s;
		acq_pkg::sample_t got;
		int k;
		wait (rst_n === 1'b1);
		for (k = 0; k < NUM_SAMPLES; k++) begin
			do begin
				@(posedge clock);
				#2;
			end while (!soc);
			// buffer has judged the previous sample three cycles ago
			if (k > 0 && !dsr_val[k-1]) begin
				compare_flag(error, 1'b1, "error after sample met dsr low");
				in_flight--;
				$display("sample %0d: dropped on dsr low, error %b", k - 1, error);
			end
			s.channel = 3'(k % acq_pkg::NUM_CHANNELS);
			s.data    = conv_data[k];
			got.channel = channel;
			got.data    = conv_data[k];
			compare_sample(got, s, "channel at soc rise");
			compare_flag(mux_en, 1'b1, "mux_en at soc rise");
			exp_q.push_back(s);
			drop_q.push_back(!dsr_val[k]);
			in_flight++;
			if (in_flight > 3) begin
				report_failure("more than three samples in flight, soc rose under back-pressure");
			end
			data_in = conv_data[k];
			// one dsr value per sample, fixed before the buffer looks at it
			dsr = dsr_val[k];
			repeat (busy_len[k]) begin
				@(posedge clock);
				#2;
				compare_flag(mux_en, 1'b1, "mux_en during conversion");
			end
			eoc = 1'b0;
			do begin
				@(posedge clock);
				#2;
			end while (soc);
			compare_flag(mux_en, 1'b0, "mux_en after capture");
			eoc = 1'b1;
			conv_count++;
		end
	end

	// line receiver, every cycle of a bit must match its midpoint value
	initial begin : line_receiver
		acq_pkg::sample_t e;
		logic [9:0] bits;
		logic cur;
		int n;
		int idx;
		int err0;
		idx = 0;
		wait (rst_n === 1'b1);
		forever begin
			@(posedge clock);
			#2;
			if (!data_out) begin
				err0 = errors;
				e = '0;
				compare_flag(error, 1'b0, "error at frame start");
				// dropped samples never reach the line
				while (drop_q.size() > 0 && drop_q[0]) begin
					void'(exp_q.pop_front());
					void'(drop_q.pop_front());
					idx++;
				end
				for (n = 0; n < FRAME_CYCLES; n++) begin
					if (n > 0) begin
						@(posedge clock);
						#2;
					end
					if (n % BITS == 0) begin
						cur = data_out;
					end else if (data_out !== cur) begin
						report_failure("data_out changed inside a bit period");
					end
					// bits[9] start, bits[8:1] data msb first, bits[0] stop
					if (n % BITS == BITS / 2) begin
						bits[9 - n / BITS] = data_out;
					end
				end
				compare_flag(bits[9], 1'b0, "start bit");
				if (bits[0] !== 1'b1) begin
					report_failure("stop bit missing, line low at stop bit midpoint");
				end
				if (exp_q.size() == 0) begin
					report_failure("frame received with no sample pending");
				end else begin
					e = exp_q.pop_front();
					void'(drop_q.pop_front());
					compare_byte(bits[8:1], e.data, "frame data");
				end
				frames_rx++;
				in_flight--;
				$display("frame %0d, sample %0d ch %0d byte %02h: %s", frames_rx, idx,
					e.channel, bits[8:1], (errors == err0) ? "ok" : "FAILED");
				idx++;
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : main_sequence
		int k;
		rst_n   = 1'b0;
		eoc     = 1'b1;
		data_in = 8'h00;
		dsr     = 1'b1;
		void'($urandom(32'hb214_4353));
		for (k = 0; k < NUM_SAMPLES; k++) begin
			busy_len[k]  = $urandom_range(12, 1);
			conv_data[k] = 8'($urandom());
			// low about one sample in six
			dsr_val[k] = ($urandom_range(5, 0) != 0);
			if (dsr_val[k]) begin
				exp_frames++;
			end
		end
		repeat (10) @(posedge clock);
		#2;
		rst_n = 1'b1;
		compare_flag(soc, 1'b0, "soc after reset");
		compare_flag(mux_en, 1'b0, "mux_en after reset");
		compare_flag(error, 1'b0, "error after reset");
		compare_flag(data_out, 1'b1, "data_out after reset");
		$display("reset: %s", (errors == 0) ? "ok" : "FAILED");

		wait (frames_rx == exp_frames && conv_count == NUM_SAMPLES);
		// line sits at mark level once the last frame is out
		repeat (2 * BITS) begin
			@(posedge clock);
			#2;
			compare_flag(data_out, 1'b1, "line idle after last frame");
		end
		while (drop_q.size() > 0 && drop_q[0]) begin
			void'(exp_q.pop_front());
			void'(drop_q.pop_front());
		end
		if (exp_q.size() != 0) begin
			report_failure("samples converted but never sent on the line");
		end
		compare_flag(error, !dsr_val[NUM_SAMPLES-1], "error flag at end of run");
		$display("samples %0d, frames %0d, dropped %0d, checks %0d, errors %0d",
			conv_count, frames_rx, conv_count - frames_rx, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src/acq_pkg.sv
`default_nettype none

package acq_pkg;

	// number of analog channels, scanned 0 up to NUM_CHANNELS-1 then back to 0
	localparam int NUM_CHANNELS = 8;

	// clock cycles per serial bit on data_out
	// any value of 2 or more works
	localparam int BIT_CYCLES = 16;

	// bit timer counter width, must hold BIT_CYCLES-1
	localparam int BIT_CNT_W = 5;

	// conversion sequencer states
	typedef enum logic [2:0] {
		// drive channel, enable the mux
		SEQ_SELECT  = 3'd0,
		// one cycle for the mux output to settle
		SEQ_SETTLE  = 3'd1,
		// raise soc
		SEQ_START   = 3'd2,
		// wait for eoc low
		SEQ_CONVERT = 3'd3,
		// latch the result
		SEQ_CAPTURE = 3'd4,
		// hold smp_valid until taken
		SEQ_OFFER   = 3'd5
	} seq_state_t;

	// serial frame states
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,
		TX_DATA  = 2'd2,
		TX_STOP  = 2'd3
	} tx_state_t;

	// one converted sample, tagged with its channel
	typedef struct packed {
		logic [$clog2(NUM_CHANNELS)-1:0] channel;
		logic [7:0]                      data;
	} sample_t;

endpackage

`default_nettype wire

// File: src/acq_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module acq_sequencer (
	input  wire                   clock,
	input  wire                   rst_n,
	// converter busy, low when the result is ready
	input  wire                   eoc,
	input  wire [7:0]             data_in,
	output logic                  soc,
	output logic                  mux_en,
	output logic [2:0]            channel,
	output logic                  smp_valid,
	output acq_pkg::sample_t      smp,
	input  wire                   smp_ready
);

	acq_pkg::seq_state_t state;

	// channel being converted now
	logic [2:0] ch_cnt;
	logic [2:0] ch_next;

	// wrap after the last channel
	assign ch_next = (ch_cnt == 3'(acq_pkg::NUM_CHANNELS - 1)) ? 3'd0 : ch_cnt + 3'd1;

	assign channel   = ch_cnt;
	assign smp_valid = (state == acq_pkg::SEQ_OFFER);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state  <= acq_pkg::SEQ_SELECT;
			ch_cnt <= 3'd0;
			soc    <= 1'b0;
			mux_en <= 1'b0;
		end else begin
			case (state)
				acq_pkg::SEQ_SELECT: begin
					// channel is already on the pins, open the mux
					mux_en <= 1'b1;
					state  <= acq_pkg::SEQ_SETTLE;
				end
				acq_pkg::SEQ_SETTLE: begin
					state <= acq_pkg::SEQ_START;
				end
				acq_pkg::SEQ_START: begin
					soc   <= 1'b1;
					state <= acq_pkg::SEQ_CONVERT;
				end
				acq_pkg::SEQ_CONVERT: begin
					// conversion length varies, eoc low ends it
					if (!eoc) begin
						state <= acq_pkg::SEQ_CAPTURE;
					end
				end
				acq_pkg::SEQ_CAPTURE: begin
					soc    <= 1'b0;
					mux_en <= 1'b0;
					state  <= acq_pkg::SEQ_OFFER;
				end
				acq_pkg::SEQ_OFFER: begin
					// stall here under back-pressure, no new conversion
					if (smp_ready) begin
						ch_cnt <= ch_next;
						state  <= acq_pkg::SEQ_SELECT;
					end
				end
				default: begin
					state <= acq_pkg::SEQ_SELECT;
				end
			endcase
		end
	end

	// result register, loaded while soc still holds the converter output
	always_ff @(posedge clock) begin
		if (state == acq_pkg::SEQ_CAPTURE) begin
			smp.channel <= ch_cnt;
			smp.data    <= data_in;
		end
	end

	// soc must be back low before a new channel is selected
	a_no_soc_in_select: assert property (
		@(posedge clock) disable iff (!rst_n)
		(state == acq_pkg::SEQ_SELECT) |-> !soc
	);

	// offered sample stays put until the buffer takes it
	a_smp_hold: assert property (
		@(posedge clock) disable iff (!rst_n)
		(smp_valid && !smp_ready) |=> (smp_valid && $stable(smp))
	);

endmodule

`default_nettype wire

// File: src/acq_top.sv
`timescale 1ns/1ps
`default_nettype none

module acq_top (
	input  wire       clock,
	input  wire       rst_n,
	input  wire       eoc,
	input  wire [7:0] data_in,
	input  wire       dsr,
	output wire       soc,
	output wire       mux_en,
	output wire [2:0] channel,
	output wire       data_out,
	output wire       error
);

	// sequencer to buffer
	wire              smp_valid;
	wire              smp_ready;
	acq_pkg::sample_t smp;

	// buffer to shifter
	wire              byte_valid;
	wire              byte_ready;
	wire [7:0]        byte_data;

	// shifter and bit timer
	wire              timer_en;
	wire              tick;

	acq_sequencer seq0 (
		.clock     (clock),
		.rst_n     (rst_n),
		.eoc       (eoc),
		.data_in   (data_in),
		.soc       (soc),
		.mux_en    (mux_en),
		.channel   (channel),
		.smp_valid (smp_valid),
		.smp       (smp),
		.smp_ready (smp_ready)
	);

	tx_buffer buf0 (
		.clock      (clock),
		.rst_n      (rst_n),
		.smp_valid  (smp_valid),
		.smp        (smp),
		.smp_ready  (smp_ready),
		.dsr        (dsr),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_ready (byte_ready),
		.error      (error)
	);

	serial_shifter shf0 (
		.clock      (clock),
		.rst_n      (rst_n),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_ready (byte_ready),
		.timer_en   (timer_en),
		.tick       (tick),
		.data_out   (data_out)
	);

	bit_timer tmr0 (
		.clock    (clock),
		.rst_n    (rst_n),
		.timer_en (timer_en),
		.tick     (tick)
	);

endmodule

`default_nettype wire

// File: src/bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

module bit_timer (
	input  wire  clock,
	input  wire  rst_n,
	// high for the whole frame
	input  wire  timer_en,
	// one cycle pulse at the end of each bit period
	output logic tick
);

	logic [acq_pkg::BIT_CNT_W-1:0] cnt;
	logic                          last;

	assign last = (cnt == acq_pkg::BIT_CNT_W'(acq_pkg::BIT_CYCLES - 1));
	assign tick = last;

	always_ff @(posedge clock) begin
		if (!rst_n || !timer_en) begin
			// idle timer sits at zero so a frame starts a full period
			cnt <= '0;
		end else if (last) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// shifter drops timer_en on the stop tick, counter must be at zero by then
	a_no_tick_idle: assert property (
		@(posedge clock) disable iff (!rst_n)
		!timer_en |-> !tick
	);

endmodule

`default_nettype wire

// File: src/serial_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module serial_shifter (
	input  wire        clock,
	input  wire        rst_n,
	input  wire        byte_valid,
	input  wire [7:0]  byte_data,
	output logic       byte_ready,
	output logic       timer_en,
	input  wire        tick,
	// serial line, idles high
	output logic       data_out
);

	acq_pkg::tx_state_t state;

	logic [7:0] shreg;
	logic [2:0] bit_idx;

	assign byte_ready = (state == acq_pkg::TX_IDLE);
	// timer runs from the transfer edge to the end of the stop bit
	assign timer_en   = (state != acq_pkg::TX_IDLE);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state    <= acq_pkg::TX_IDLE;
			bit_idx  <= 3'd0;
			data_out <= 1'b1;
		end else begin
			case (state)
				acq_pkg::TX_IDLE: begin
					if (byte_valid) begin
						// start bit goes out right away
						data_out <= 1'b0;
						bit_idx  <= 3'd0;
						state    <= acq_pkg::TX_START;
					end
				end
				acq_pkg::TX_START: begin
					if (tick) begin
						data_out <= shreg[7];
						state    <= acq_pkg::TX_DATA;
					end
				end
				acq_pkg::TX_DATA: begin
					if (tick) begin
						if (bit_idx == 3'd7) begin
							// stop bit
							data_out <= 1'b1;
							state    <= acq_pkg::TX_STOP;
						end else begin
							data_out <= shreg[7];
							bit_idx  <= bit_idx + 3'd1;
						end
					end
				end
				acq_pkg::TX_STOP: begin
					if (tick) begin
						state <= acq_pkg::TX_IDLE;
					end
				end
				default: begin
					state    <= acq_pkg::TX_IDLE;
					data_out <= 1'b1;
				end
			endcase
		end
	end

	// msb first, next bit always sits in shreg[7]
	always_ff @(posedge clock) begin
		if (state == acq_pkg::TX_IDLE && byte_valid) begin
			shreg <= byte_data;
		end else if (tick && state != acq_pkg::TX_STOP) begin
			shreg <= {shreg[6:0], 1'b0};
		end
	end

	// line must be back at mark level whenever no frame is running
	a_idle_high: assert property (
		@(posedge clock) disable iff (!rst_n)
		(state == acq_pkg::TX_IDLE) |-> data_out
	);

endmodule

`default_nettype wire

// File: src/tx_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_buffer (
	input  wire              clock,
	input  wire              rst_n,
	input  wire              smp_valid,
	input  wire acq_pkg::sample_t smp,
	output logic             smp_ready,
	// data set ready from the line side
	input  wire              dsr,
	output logic             byte_valid,
	output logic [7:0]       byte_data,
	input  wire              byte_ready,
	// sticky until the next byte goes out
	output logic             error
);

	logic       full;
	// dsr already seen high for the held byte
	logic       passed;
	logic [7:0] data_q;

	logic       take;
	logic       give;
	logic       drop;

	// empty buffer always accepts
	assign smp_ready = !full;
	assign take      = smp_valid && smp_ready;

	// dsr only matters on the first full cycle and the offer stays after that
	assign byte_valid = full && (passed || dsr);
	assign byte_data  = data_q;
	assign give       = byte_valid && byte_ready;

	// dsr low on the check cycle throws the sample away
	assign drop = full && !passed && !dsr;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			full   <= 1'b0;
			passed <= 1'b0;
			error  <= 1'b0;
		end else begin
			if (take) begin
				full   <= 1'b1;
				passed <= 1'b0;
			end else if (give || drop) begin
				full   <= 1'b0;
				passed <= 1'b0;
			end else if (byte_valid) begin
				// busy shifter keeps the byte offered whatever dsr does
				passed <= 1'b1;
			end

			if (drop) begin
				error <= 1'b1;
			end else if (give) begin
				error <= 1'b0;
			end
		end
	end

	// only the byte is kept and the channel tag ends here
	always_ff @(posedge clock) begin
		if (take) begin
			data_q <= smp.data;
		end
	end

	// a sample either goes out or is flagged but never both
	a_valid_or_error: assert property (
		@(posedge clock) disable iff (!rst_n)
		!($rose(byte_valid) && $rose(error))
	);

endmodule

`default_nettype wire

// File: vlog.f
src/acq_pkg.sv
src/acq_sequencer.sv
src/bit_timer.sv
src/tx_buffer.sv
src/serial_shifter.sv
src/acq_top.sv
dv/acq_tb.sv
